// File: stageDma_cfg.svh
`ifndef STAGE_DMA_CFG_SVH
`define STAGE_DMA_CFG_SVH

// Byte address width
`define ADDR_W 32

// Memory word width
`define DATA_W 64

// Line buffer entries
`define BUF_DEPTH 8

// Significant bits of the length field
`define LEN_W 28

`endif

// File: stageDmaPkg.sv
`include "stageDma_cfg.svh"

package stageDmaPkg;

  typedef logic [`ADDR_W-1:0] addrT;
  typedef logic [`DATA_W-1:0] wordT;

  // Word count, also wide enough for buffer occupancy
  typedef logic [`LEN_W-4:0] countT;

  typedef enum logic [1:0] {
    rdIdle,
    rdRun,
    rdDrain   // All requests issued, data still returning
  } rdStateT;

  typedef enum logic [1:0] {
    wrIdle,
    wrRun,
    wrWait    // Write request out, waiting for ack
  } wrStateT;

endpackage

// File: streamIf.sv
`timescale 1ns/10ps
`include "stageDma_cfg.svh"

interface streamIf;

  logic valid;
  logic ready;
  stageDmaPkg::wordT data;
  logic last;                 // Final word of a job
  stageDmaPkg::countT level;  // Words held on the sink side

  modport src (output valid, output data, output last, input ready, input level);

  modport snk (input valid, input data, input last, output ready, output level);

endinterface

// File: dramReader.sv
`timescale 1ns/10ps
`include "stageDma_cfg.svh"

module dramReader (
  input  logic FCLK0,
  input  logic rstN,
  input  logic start,
  input  stageDmaPkg::addrT srcAddr,
  input  stageDmaPkg::countT nWords,
  output logic idle,
  output logic rdReq,
  output stageDmaPkg::addrT rdAddr,
  input  logic rdAck,
  input  logic rdValid,
  input  stageDmaPkg::wordT rdData,
  streamIf.src dataOut
);

  import stageDmaPkg::*;

  rdStateT state;
  countT reqLeft;    // Requests still to issue
  countT rxLeft;     // Words still to come back
  countT inFlight;   // Acked reads not yet returned
  logic reqDone;
  logic take;
  logic haveSpace;

  assign reqDone = rdReq && rdAck;
  assign take = dataOut.valid && dataOut.ready;

  // Room for one more word once all reads in flight have landed
  assign haveSpace = (inFlight + dataOut.level) < countT'(`BUF_DEPTH);

  // Returned data goes straight on, the space rule keeps the buffer from filling
  assign dataOut.valid = rdValid;
  assign dataOut.data = rdData;
  assign dataOut.last = (rxLeft == countT'(1));

  assign idle = (state == rdIdle);

  always_ff @(posedge FCLK0) begin
    if (!rstN) begin
      state <= rdIdle;
      rdReq <= 1'b0;
      reqLeft <= '0;
      rxLeft <= '0;
      inFlight <= '0;
    end else begin
      inFlight <= inFlight + countT'(reqDone) - countT'(take);
      if (take) begin
        rxLeft <= rxLeft - 1'b1;
      end

      case (state)
        rdIdle: begin
          if (start) begin
            reqLeft <= nWords;
            rxLeft <= nWords;
            state <= rdRun;
          end
        end
        rdRun: begin
          if (rdReq) begin
            if (rdAck) begin
              rdReq <= 1'b0;  // Low for a cycle after each ack
              reqLeft <= reqLeft - 1'b1;
              if (reqLeft == countT'(1)) begin
                state <= rdDrain;
              end
            end
          end else if (haveSpace) begin
            rdReq <= 1'b1;
          end
        end
        rdDrain: begin
          if (inFlight == '0) begin
            state <= rdIdle;
          end
        end
        default: state <= rdIdle;
      endcase
    end
  end

  always_ff @(posedge FCLK0) begin
    if (idle && start) begin
      rdAddr <= srcAddr;
    end else if (reqDone) begin
      rdAddr <= rdAddr + addrT'(8);
    end
  end

endmodule

// File: lineBuffer.sv
`timescale 1ns/10ps
`include "stageDma_cfg.svh"

module lineBuffer (
  input  logic FCLK0,
  input  logic rstN,
  streamIf.snk dataIn,
  streamIf.src dataOut
);

  import stageDmaPkg::*;

  localparam int PTR_W = $clog2(`BUF_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  wordT dataMem [`BUF_DEPTH];
  logic lastMem [`BUF_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic push;
  logic pop;
  logic full;
  logic empty;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    nextPtr = (ptr == PTR_W'(`BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full = (count == CNT_W'(`BUF_DEPTH));
  assign empty = (count == '0);
  assign push = dataIn.valid && dataIn.ready;
  assign pop = dataOut.valid && dataOut.ready;

  assign dataIn.ready = !full;
  assign dataOut.valid = !empty;
  assign dataOut.data = dataMem[rdPtr];
  assign dataOut.last = lastMem[rdPtr];

  // Occupancy also counts the word the writer is holding
  assign dataIn.level = countT'(count) + dataOut.level;

  always_ff @(posedge FCLK0) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge FCLK0) begin
    if (push) begin
      dataMem[wrPtr] <= dataIn.data;
      lastMem[wrPtr] <= dataIn.last;
    end
  end

endmodule

// File: dramWriter.sv
`timescale 1ns/10ps
`include "stageDma_cfg.svh"

module dramWriter (
  input  logic FCLK0,
  input  logic rstN,
  input  logic start,
  input  stageDmaPkg::addrT dstAddr,
  output logic idle,
  streamIf.snk dataIn,
  output logic wrReq,
  output stageDmaPkg::addrT wrAddr,
  output stageDmaPkg::wordT wrData,
  input  logic wrAck
);

  import stageDmaPkg::*;

  wrStateT state;
  logic lastHeld;   // Held word ends the job
  logic ackNow;
  logic take;

  assign ackNow = wrReq && wrAck;

  // Next word can be taken in the same cycle as the ack
  assign dataIn.ready = (state == wrRun) || ((state == wrWait) && ackNow && !lastHeld);
  assign take = dataIn.valid && dataIn.ready;

  assign dataIn.level = (state == wrWait) ? countT'(1) : '0;

  assign idle = (state == wrIdle);

  always_ff @(posedge FCLK0) begin
    if (!rstN) begin
      state <= wrIdle;
      wrReq <= 1'b0;
    end else begin
      case (state)
        wrIdle: begin
          if (start) begin
            state <= wrRun;
          end
        end
        wrRun: begin
          if (take) begin
            wrReq <= 1'b1;
            state <= wrWait;
          end
        end
        wrWait: begin
          if (ackNow) begin
            if (lastHeld) begin
              wrReq <= 1'b0;
              state <= wrIdle;
            end else if (!take) begin
              wrReq <= 1'b0;  // Nothing queued yet
              state <= wrRun;
            end
          end
        end
        default: state <= wrIdle;
      endcase
    end
  end

  always_ff @(posedge FCLK0) begin
    if (take) begin
      wrData <= dataIn.data;
      lastHeld <= dataIn.last;
    end
    if (idle && start) begin
      wrAddr <= dstAddr;
    end else if (ackNow) begin
      wrAddr <= wrAddr + addrT'(8);
    end
  end

endmodule

// File: stageDma.sv
`timescale 1ns/10ps
`include "stageDma_cfg.svh"

module stageDma (
  input  logic FCLK0,
  input  logic rstN,

  input  logic configValid,
  input  stageDmaPkg::addrT configSrc,
  input  stageDmaPkg::addrT configDest,
  input  logic [31:0] configLen,
  output logic configReady,

  output logic rdReq,
  output stageDmaPkg::addrT rdAddr,
  input  logic rdAck,
  input  logic rdValid,
  input  stageDmaPkg::wordT rdData,

  output logic wrReq,
  output stageDmaPkg::addrT wrAddr,
  output stageDmaPkg::wordT wrData,
  input  logic wrAck
);

  import stageDmaPkg::*;

  logic readerIdle;
  logic writerIdle;
  logic start;
  countT nWords;

  streamIf inStream();
  streamIf outStream();

  // Only take a job when both ends are idle
  assign configReady = readerIdle && writerIdle;
  assign start = configValid && configReady;

  assign nWords = configLen[`LEN_W-1:3];  // Upper length bits ignored

  dramReader dramReader_i (
    .FCLK0   (FCLK0),
    .rstN    (rstN),
    .start   (start),
    .srcAddr (configSrc),
    .nWords  (nWords),
    .idle    (readerIdle),
    .rdReq   (rdReq),
    .rdAddr  (rdAddr),
    .rdAck   (rdAck),
    .rdValid (rdValid),
    .rdData  (rdData),
    .dataOut (inStream)
  );

  lineBuffer lineBuffer_i (
    .FCLK0   (FCLK0),
    .rstN    (rstN),
    .dataIn  (inStream),
    .dataOut (outStream)
  );

  dramWriter dramWriter_i (
    .FCLK0   (FCLK0),
    .rstN    (rstN),
    .start   (start),
    .dstAddr (configDest),
    .idle    (writerIdle),
    .dataIn  (outStream),
    .wrReq   (wrReq),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .wrAck   (wrAck)
  );

endmodule

// File: stageDma_sva.sv
`timescale 1ns/10ps

module stageDmaSva (
  input logic FCLK0,
  input logic rstN,
  input logic configReady,
  input logic rdReq,
  input stageDmaPkg::addrT rdAddr,
  input logic rdAck,
  input logic wrReq,
  input stageDmaPkg::addrT wrAddr,
  input stageDmaPkg::wordT wrData,
  input logic wrAck
);

  rdHold: assert property (@(posedge FCLK0) disable iff (!rstN)
    rdReq && !rdAck |=> rdReq && $stable(rdAddr))
    else $error("rdReq or rdAddr changed before rdAck");

  wrHold: assert property (@(posedge FCLK0) disable iff (!rstN)
    wrReq && !wrAck |=> wrReq && $stable(wrAddr) && $stable(wrData))
    else $error("wrReq, wrAddr or wrData changed before wrAck");

  // No memory traffic while idle
  idleQuiet: assert property (@(posedge FCLK0) disable iff (!rstN)
    configReady |-> !rdReq && !wrReq)
    else $error("memory request seen while configReady is high");

endmodule

bind stageDma stageDmaSva stageDmaSva_i (
  .FCLK0       (FCLK0),
  .rstN        (rstN),
  .configReady (configReady),
  .rdReq       (rdReq),
  .rdAddr      (rdAddr),
  .rdAck       (rdAck),
  .wrReq       (wrReq),
  .wrAddr      (wrAddr),
  .wrData      (wrData),
  .wrAck       (wrAck)
);

// File: stageDma_tb.sv
`timescale 1ns/10ps
`include "stageDma_cfg.svh"

module stageDmaTb;

  import stageDmaPkg::*;

  logic FCLK0;
  logic rstN;
  logic configValid;
  addrT configSrc;
  addrT configDest;
  logic [31:0] configLen;
  logic configReady;
  logic rdReq;
  addrT rdAddr;
  logic rdAck = 1'b0;
  logic rdValid = 1'b0;
  wordT rdData = '0;
  logic wrReq;
  addrT wrAddr;
  wordT wrData;
  logic wrAck = 1'b0;
  logic wrStall = 1'b0;   // Holds back write acks

  integer seed = 33;
  int cycle = 0;
  int rdDelay = 0;
  int wrDelay = 0;
  int readsAcked = 0;
  int writesAcked = 0;
  int maxOutstanding = 0;
  addrT pendAddr[$];      // Reads acked, data not yet returned
  int pendDue[$];
  addrT wrAddrLog[$];
  wordT wrDataLog[$];

  string testName;
  int testErrors;
  int okCount = 0;
  int badCount = 0;

  stageDma stageDma_i (
    .FCLK0       (FCLK0),
    .rstN        (rstN),
    .configValid (configValid),
    .configSrc   (configSrc),
    .configDest  (configDest),
    .configLen   (configLen),
    .configReady (configReady),
    .rdReq       (rdReq),
    .rdAddr      (rdAddr),
    .rdAck       (rdAck),
    .rdValid     (rdValid),
    .rdData      (rdData),
    .wrReq       (wrReq),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .wrAck       (wrAck)
  );

  initial begin
    FCLK0 = 1'b0;
    forever #10 FCLK0 = ~FCLK0;
  end

  // Memory content seen at a byte address
  function automatic wordT modelWord(input addrT a);
    modelWord = {~a, a};
  endfunction

  function automatic int randDelay();
    randDelay = int'($unsigned($random(seed)) % 32'd4);
  endfunction

  // Memory model for both ports
  always @(posedge FCLK0) begin
    cycle = cycle + 1;
    if (!rstN) begin
      rdAck <= 1'b0;
      rdValid <= 1'b0;
      wrAck <= 1'b0;
      pendAddr.delete();
      pendDue.delete();
    end else begin
      if (pendDue.size() > 0 && pendDue[0] <= cycle) begin
        rdValid <= 1'b1;
        rdData <= modelWord(pendAddr.pop_front());
        void'(pendDue.pop_front());
      end else begin
        rdValid <= 1'b0;
      end
      if (rdReq && rdAck) begin
        pendAddr.push_back(rdAddr);
        pendDue.push_back(cycle + 1 + randDelay());  // In-order latency of 1 to 4 cycles
        readsAcked++;
        rdAck <= 1'b0;
        rdDelay = randDelay();
      end else if (rdReq) begin
        if (rdDelay == 0) begin
          rdAck <= 1'b1;
        end else begin
          rdDelay--;
        end
      end
      if (wrReq && wrAck) begin
        wrAddrLog.push_back(wrAddr);
        wrDataLog.push_back(wrData);
        writesAcked++;
        wrAck <= 1'b0;
        wrDelay = randDelay();
      end else if (wrReq && !wrStall) begin
        if (wrDelay == 0) begin
          wrAck <= 1'b1;
        end else begin
          wrDelay--;
        end
      end
      if (readsAcked - writesAcked > maxOutstanding) begin
        maxOutstanding = readsAcked - writesAcked;
      end
    end
  end

  task automatic reportMismatch(input wordT expected, input wordT actual);
    $display("Fail %s: expected %0h, actual %0h", testName, expected, actual);
    testErrors++;
  endtask

  task automatic beginTest(input string name);
    testName = name;
    testErrors = 0;
    wrAddrLog.delete();
    wrDataLog.delete();
  endtask

  task automatic endTest();
    if (testErrors == 0) begin
      $display("%s: ok", testName);
      okCount++;
    end else begin
      $display("%s: %0d errors", testName, testErrors);
      badCount++;
    end
  endtask

  // Configuration strobe held for the given number of cycles
  task automatic pulseConfig(input addrT src, input addrT dst, input logic [31:0] len,
                             input int width);
    @(posedge FCLK0);
    configValid <= 1'b1;
    configSrc <= src;
    configDest <= dst;
    configLen <= len;
    repeat (width) @(posedge FCLK0);
    configValid <= 1'b0;
  endtask

  task automatic waitIdle(input int limit, input bit stallOn);
    int i;
    for (i = 0; i < limit; i++) begin
      @(posedge FCLK0);
      if (stallOn) begin
        wrStall <= ((i % 60) < 45);  // Long gaps without write acks
      end
      if (configReady) begin
        break;
      end
    end
    wrStall <= 1'b0;
    if (i == limit) begin
      $display("Timeout in %s: configReady stayed low for %0d cycles", testName, limit);
      testErrors++;
    end
  endtask

  // Word k lands at dst + 8k with the memory word from src + 8k
  task automatic checkWrites(input addrT src, input addrT dst, input int n);
    int k;
    addrT offset;
    if (wrAddrLog.size() != n) begin
      reportMismatch(wordT'(n), wordT'(wrAddrLog.size()));
    end
    for (k = 0; k < n && k < wrAddrLog.size(); k++) begin
      offset = addrT'(8 * k);
      if (wrAddrLog[k] !== dst + offset) begin
        reportMismatch(wordT'(dst + offset), wordT'(wrAddrLog[k]));
      end
      if (wrDataLog[k] !== modelWord(src + offset)) begin
        reportMismatch(modelWord(src + offset), wrDataLog[k]);
      end
    end
  endtask

  task automatic resetDefaults();
    beginTest("resetState");
    @(posedge FCLK0);
    if (configReady !== 1'b1) begin
      reportMismatch(wordT'(1), wordT'(configReady));
    end
    if (rdReq !== 1'b0) begin
      reportMismatch(wordT'(0), wordT'(rdReq));
    end
    if (wrReq !== 1'b0) begin
      reportMismatch(wordT'(0), wordT'(wrReq));
    end
    endTest();
  endtask

  task automatic singleWordCopy();
    beginTest("singleWord");
    pulseConfig(32'h0000_1000, 32'h0008_0000, 32'd8, 1);
    waitIdle(200, 1'b0);
    checkWrites(32'h0000_1000, 32'h0008_0000, 1);
    endTest();
  endtask

  task automatic burstCopy();
    beginTest("burst256");
    pulseConfig(32'h0001_0000, 32'h0040_0100, 32'hF000_0100, 1);  // Top bits must be ignored
    waitIdle(2000, 1'b0);
    checkWrites(32'h0001_0000, 32'h0040_0100, 32);
    endTest();
  endtask

  task automatic stalledWriteBound();
    beginTest("bufferBound");
    maxOutstanding = 0;
    pulseConfig(32'h0002_0008, 32'h0050_0000, 32'd256, 1);
    waitIdle(6000, 1'b1);
    if (maxOutstanding > `BUF_DEPTH) begin
      $display("%s: %0d words were held between read and write, more than %0d",
               testName, maxOutstanding, `BUF_DEPTH);
      testErrors++;
    end
    checkWrites(32'h0002_0008, 32'h0050_0000, 32);
    endTest();
  endtask

  task automatic busyConfigIgnored();
    int readsBefore;
    beginTest("busyIgnore");
    readsBefore = readsAcked;
    wrStall <= 1'b1;  // Writer stuck on its first word keeps the stage busy
    pulseConfig(32'h0003_0000, 32'h0060_0000, 32'd64, 1);
    // Offered until well after the reader has gone idle
    pulseConfig(32'h0004_0000, 32'h0070_0000, 32'd64, 100);
    wrStall <= 1'b0;
    if (readsAcked - readsBefore != 8) begin
      reportMismatch(wordT'(8), wordT'(readsAcked - readsBefore));
    end
    waitIdle(1000, 1'b0);
    checkWrites(32'h0003_0000, 32'h0060_0000, 8);
    wrAddrLog.delete();
    wrDataLog.delete();
    pulseConfig(32'h0005_0000, 32'h0078_0000, 32'd64, 1);
    waitIdle(1000, 1'b0);
    checkWrites(32'h0005_0000, 32'h0078_0000, 8);
    endTest();
  endtask

  initial begin
    rstN = 1'b0;
    configValid = 1'b0;
    configSrc = '0;
    configDest = '0;
    configLen = '0;
    repeat (8) @(posedge FCLK0);
    rstN <= 1'b1;
    resetDefaults();
    singleWordCopy();
    burstCopy();
    stalledWriteBound();
    busyConfigIgnored();
    $display("Summary: %0d tests ok, %0d tests with errors", okCount, badCount);
    if (badCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: stageDma.f
+incdir+.
stageDmaPkg.sv
streamIf.sv
dramReader.sv
lineBuffer.sv
dramWriter.sv
stageDma.sv
stageDma_sva.sv
stageDma_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module stageDmaTb -o stageDmaSim -f stageDma.f \
  && ./obj_dir/stageDmaSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^test passed$" sim.log 2>/dev/null && exit 0 || exit 1
